/* src/regman_pkg.sv */
package regman_pkg;

    // datapath width
    localparam int LEN_WORD = 32;

    // architectural register address
    localparam int LEN_PREG_ADDR = 5;
    localparam int NUM_REGS = 2 ** LEN_PREG_ADDR;

    // one bit per speculative region
    localparam int LEN_CONTEXT = 4;

    typedef logic [LEN_WORD-1:0] word_t;

    typedef logic [LEN_PREG_ADDR-1:0] preg_addr_t;

    // zero means no outstanding write
    typedef logic [LEN_CONTEXT-1:0] context_t;

    // link register
    localparam preg_addr_t LR_ADDR = 5'd1;

    localparam context_t CONTEXT_ZERO = '0;

endpackage

/* src/pipe_pkg.sv */
package pipe_pkg;

    import regman_pkg::*;

    // decode to register manager
    typedef struct packed {
        logic       valid;
        logic       rs1_use;
        preg_addr_t rs1;
        logic       rs2_use;
        preg_addr_t rs2;
        logic       rd_use;
        preg_addr_t rd;
        context_t   ctx;
    } issue_req_t;

    // same-cycle answer to decode
    typedef struct packed {
        logic  grant;
        word_t rs1_data;
        word_t rs2_data;
    } issue_rsp_t;

    // one result per cycle from execute
    typedef struct packed {
        logic       valid;
        preg_addr_t rd;
        word_t      data;
    } wb_t;

endpackage

/* src/reg_file.sv */
module reg_file
    import regman_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  preg_addr_t rd_addr_a,
    input  preg_addr_t rd_addr_b,
    output word_t      rd_data_a,
    output word_t      rd_data_b,
    output word_t      lr_data,
    input  logic       wr_en,
    input  preg_addr_t wr_addr,
    input  word_t      wr_data
);

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, x0 hardwired
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

    // dedicated link register tap
    assign lr_data = regs[LR_ADDR];

    // the writeback path filters x0 before it gets here
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> wr_addr != '0
    );

endmodule

/* src/ctx_scoreboard.sv */
module ctx_scoreboard
    import regman_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  issue_req_t req,
    input  logic       wb_valid,
    input  preg_addr_t wb_rd,
    input  logic       branch_hazard,
    input  context_t   hazard_context,
    output logic       grant,
    output logic       lr_dirty
);

    // context of the single outstanding writer per register
    context_t pending      [NUM_REGS];
    context_t pending_next [NUM_REGS];

    logic ctx_killed;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_marks;
    logic rd_ready;

    // request belongs to a region being squashed
    assign ctx_killed = branch_hazard && (|(req.ctx & hazard_context));

    // RAW check, a same-cycle writeback satisfies the source
    assign rs1_ready = !req.rs1_use
                       || pending[req.rs1] == CONTEXT_ZERO
                       || (wb_valid && wb_rd == req.rs1);
    assign rs2_ready = !req.rs2_use
                       || pending[req.rs2] == CONTEXT_ZERO
                       || (wb_valid && wb_rd == req.rs2);

    // WAW check, x0 never gets a writer
    assign rd_marks = req.rd_use && req.rd != '0;
    assign rd_ready = !rd_marks || pending[req.rd] == CONTEXT_ZERO;

    assign grant = req.valid && !ctx_killed && rs1_ready && rs2_ready && rd_ready;

    // squash, then clear, then mark
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            pending_next[i] = pending[i];
            if (branch_hazard && (|(pending[i] & hazard_context))) begin
                pending_next[i] = CONTEXT_ZERO;
            end
            if (wb_valid && wb_rd == preg_addr_t'(i)) begin
                pending_next[i] = CONTEXT_ZERO;
            end
            // new writer survives a same-cycle writeback clear
            if (grant && rd_marks && req.rd == preg_addr_t'(i)) begin
                pending_next[i] = req.ctx;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                pending[i] <= CONTEXT_ZERO;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                pending[i] <= pending_next[i];
            end
        end
    end

    assign lr_dirty = pending[LR_ADDR] != CONTEXT_ZERO;

    // decode tags every live request with a region
    a_req_ctx_nonzero : assert property (
        @(posedge clk) disable iff (!arst_n)
        req.valid |-> req.ctx != CONTEXT_ZERO
    );

    // a pending writer is never replaced by a second one
    for (genvar g = 1; g < NUM_REGS; g++) begin : g_single_writer
        a_grant_rd_free : assert property (
            @(posedge clk) disable iff (!arst_n)
            pending[g] != CONTEXT_ZERO
                |=> pending[g] == CONTEXT_ZERO || pending[g] == $past(pending[g])
        );
    end

    a_entry0_clear : assert property (
        @(posedge clk) disable iff (!arst_n)
        pending[0] == CONTEXT_ZERO
    );

endmodule

/* src/reg_manage.sv */
module reg_manage
    import regman_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  issue_req_t issue_req,
    output issue_rsp_t issue_rsp,
    input  wb_t        wb,
    input  logic       branch_hazard,
    input  context_t   hazard_context,
    output word_t      lr_data,
    output logic       lr_dirty
);

    word_t rf_data_a;
    word_t rf_data_b;
    logic  wb_write;
    logic  grant;

    // writes to x0 are dropped here
    assign wb_write = wb.valid && wb.rd != '0;

    reg_file reg_file_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (issue_req.rs1),
        .rd_addr_b (issue_req.rs2),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b),
        .lr_data   (lr_data),
        .wr_en     (wb_write),
        .wr_addr   (wb.rd),
        .wr_data   (wb.data)
    );

    ctx_scoreboard ctx_scoreboard_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (issue_req),
        .wb_valid       (wb.valid),
        .wb_rd          (wb.rd),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .grant          (grant),
        .lr_dirty       (lr_dirty)
    );

    // bypass the writeback that lands in this cycle
    // wb_write already excludes x0, so x0 keeps reading zero
    function automatic word_t src_value(
        input preg_addr_t addr,
        input word_t      rf_value,
        input logic       fwd_en,
        input preg_addr_t fwd_addr,
        input word_t      fwd_data
    );
        if (fwd_en && fwd_addr == addr) begin
            return fwd_data;
        end
        return rf_value;
    endfunction

    always_comb begin
        issue_rsp.grant    = grant;
        issue_rsp.rs1_data = src_value(issue_req.rs1, rf_data_a, wb_write, wb.rd, wb.data);
        issue_rsp.rs2_data = src_value(issue_req.rs2, rf_data_b, wb_write, wb.rd, wb.data);
    end

endmodule

/* src/regman_top.sv */
module regman_top
    import regman_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  issue_req_t issue_req,
    output issue_rsp_t issue_rsp,
    input  wb_t        wb,
    input  logic       branch_hazard,
    input  context_t   hazard_context,
    output word_t      lr_data,
    output logic       lr_dirty
);

    // register management subsystem
    reg_manage reg_manage_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue_req      (issue_req),
        .issue_rsp      (issue_rsp),
        .wb             (wb),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .lr_data        (lr_data),
        .lr_dirty       (lr_dirty)
    );

endmodule

/* tests/tb_regman.sv */
module tb_regman
    import regman_pkg::*;
    import pipe_pkg::*;
();

    logic       clk;
    logic       arst_n;
    issue_req_t issue_req;
    issue_rsp_t issue_rsp;
    wb_t        wb;
    logic       branch_hazard;
    context_t   hazard_context;
    word_t      lr_data;
    logic       lr_dirty;

    // expected architectural state
    word_t    model_regs [NUM_REGS];
    context_t model_pend [NUM_REGS];

    logic   exp_grant;
    word_t  exp_rs1_data;
    word_t  exp_rs2_data;
    word_t  exp_lr_data;
    logic   exp_lr_dirty;
    integer seed;

    regman_top dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue_req      (issue_req),
        .issue_rsp      (issue_rsp),
        .wb             (wb),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .lr_data        (lr_data),
        .lr_dirty       (lr_dirty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, expected));
    endtask

    // expected responses for the current inputs
    always_comb begin
        logic rs1_ok;
        logic rs2_ok;
        logic rd_ok;
        logic killed;
        exp_rs1_data = model_regs[issue_req.rs1];
        exp_rs2_data = model_regs[issue_req.rs2];
        if (wb.valid && wb.rd != '0 && wb.rd == issue_req.rs1) begin
            exp_rs1_data = wb.data;
        end
        if (wb.valid && wb.rd != '0 && wb.rd == issue_req.rs2) begin
            exp_rs2_data = wb.data;
        end
        rs1_ok = !issue_req.rs1_use || model_pend[issue_req.rs1] == CONTEXT_ZERO
                 || (wb.valid && wb.rd == issue_req.rs1);
        rs2_ok = !issue_req.rs2_use || model_pend[issue_req.rs2] == CONTEXT_ZERO
                 || (wb.valid && wb.rd == issue_req.rs2);
        rd_ok = !(issue_req.rd_use && issue_req.rd != '0)
                || model_pend[issue_req.rd] == CONTEXT_ZERO;
        killed = branch_hazard && (issue_req.ctx & hazard_context) != CONTEXT_ZERO;
        exp_grant = issue_req.valid && !killed && rs1_ok && rs2_ok && rd_ok;
        exp_lr_data = model_regs[LR_ADDR];
        exp_lr_dirty = model_pend[LR_ADDR] != CONTEXT_ZERO;
    end

    // squash, then writeback clear, then mark of the new writer
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] <= '0;
                model_pend[i] <= CONTEXT_ZERO;
            end
        end else begin
            if (wb.valid && wb.rd != '0) begin
                model_regs[wb.rd] <= wb.data;
            end
            for (int i = 0; i < NUM_REGS; i++) begin
                if (branch_hazard && (model_pend[i] & hazard_context) != CONTEXT_ZERO) begin
                    model_pend[i] <= CONTEXT_ZERO;
                end
            end
            if (wb.valid) begin
                model_pend[wb.rd] <= CONTEXT_ZERO;
            end
            if (exp_grant && issue_req.rd_use && issue_req.rd != '0) begin
                model_pend[issue_req.rd] <= issue_req.ctx;
            end
        end
    end

    a_grant : assert property (@(posedge clk) disable iff (!arst_n) issue_rsp.grant == exp_grant)
        else report_mismatch("grant", word_t'($sampled(issue_rsp.grant)),
                             word_t'($sampled(exp_grant)));
    a_rs1_data : assert property (@(posedge clk) disable iff (!arst_n)
        issue_rsp.rs1_data == exp_rs1_data)
        else report_mismatch("rs1_data", $sampled(issue_rsp.rs1_data), $sampled(exp_rs1_data));
    a_rs2_data : assert property (@(posedge clk) disable iff (!arst_n)
        issue_rsp.rs2_data == exp_rs2_data)
        else report_mismatch("rs2_data", $sampled(issue_rsp.rs2_data), $sampled(exp_rs2_data));
    a_lr_data : assert property (@(posedge clk) disable iff (!arst_n) lr_data == exp_lr_data)
        else report_mismatch("lr_data", $sampled(lr_data), $sampled(exp_lr_data));
    a_lr_dirty : assert property (@(posedge clk) disable iff (!arst_n) lr_dirty == exp_lr_dirty)
        else report_mismatch("lr_dirty", word_t'($sampled(lr_dirty)),
                             word_t'($sampled(exp_lr_dirty)));

    function automatic issue_req_t make_req(input logic rs1_use, input preg_addr_t rs1,
                                            input logic rs2_use, input preg_addr_t rs2,
                                            input logic rd_use, input preg_addr_t rd,
                                            input context_t ctx);
        issue_req_t r;
        r.valid = 1'b1;
        r.rs1_use = rs1_use;
        r.rs1 = rs1;
        r.rs2_use = rs2_use;
        r.rs2 = rs2;
        r.rd_use = rd_use;
        r.rd = rd;
        r.ctx = ctx;
        return r;
    endfunction

    function automatic wb_t make_wb(input preg_addr_t rd, input word_t data);
        wb_t w;
        w.valid = 1'b1;
        w.rd = rd;
        w.data = data;
        return w;
    endfunction

    function automatic context_t one_hot(input logic [1:0] sel);
        context_t c;
        c = CONTEXT_ZERO;
        c[sel] = 1'b1;
        return c;
    endfunction

    task automatic apply(input issue_req_t r, input wb_t w, input logic hz, input context_t mask);
        @(negedge clk);
        issue_req = r;
        wb = w;
        branch_hazard = hz;
        hazard_context = mask;
    endtask

    task automatic idle(input int n);
        repeat (n) apply('0, '0, 1'b0, CONTEXT_ZERO);
    endtask

    // request is held by the caller, grant sampled mid cycle
    task automatic wait_grant();
        int cycles;
        cycles = 0;
        #1;
        while (!issue_rsp.grant) begin
            if (cycles == 50) begin
                abort_run("issue request timed out, grant never came within 50 cycles");
            end
            @(negedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic issue(input issue_req_t r);
        apply(r, '0, 1'b0, CONTEXT_ZERO);
        wait_grant();
    endtask

    task automatic random_mix(input int cycles);
        logic [31:0] r;
        issue_req_t  q;
        wb_t         w;
        for (int n = 0; n < cycles; n++) begin
            r = $random(seed);
            q = make_req(r[1], r[6:2], r[7], r[12:8], r[13], r[18:14], one_hot(r[20:19]));
            q.valid = r[0];
            w = make_wb(r[26:22], $random(seed));
            w.valid = r[21];
            // hazard in roughly one cycle of eight
            apply(q, w, r[29:27] == 3'b000, one_hot(r[31:30]));
        end
    endtask

    initial begin
        seed = 32'h88127ba5;
        arst_n = 1'b0;
        issue_req = '0;
        wb = '0;
        branch_hazard = 1'b0;
        hazard_context = CONTEXT_ZERO;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // reset values, then writeback and x0
        for (int k = 0; k < NUM_REGS; k++) begin
            apply(make_req(1'b1, preg_addr_t'(k), 1'b1, preg_addr_t'(NUM_REGS - 1 - k),
                           1'b0, '0, 4'b0001), '0, 1'b0, CONTEXT_ZERO);
        end
        apply('0, make_wb(5'd7, 32'hcafe_0007), 1'b0, CONTEXT_ZERO);
        apply(make_req(1'b1, 5'd7, 1'b1, 5'd0, 1'b0, '0, 4'b0001), '0, 1'b0, CONTEXT_ZERO);
        apply(make_req(1'b1, 5'd0, 1'b1, 5'd7, 1'b0, '0, 4'b0001),
              make_wb(5'd0, 32'hdead_beef), 1'b0, CONTEXT_ZERO);
        apply(make_req(1'b1, 5'd0, 1'b0, '0, 1'b0, '0, 4'b0001), '0, 1'b0, CONTEXT_ZERO);

        // raw stall on x5 until its writeback
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd5, 4'b0001));
        repeat (3) apply(make_req(1'b1, 5'd5, 1'b0, '0, 1'b0, '0, 4'b0001), '0, 1'b0, CONTEXT_ZERO);
        apply('0, make_wb(5'd5, 32'h0000_5555), 1'b0, CONTEXT_ZERO);
        issue(make_req(1'b1, 5'd5, 1'b0, '0, 1'b0, '0, 4'b0001));

        // forwarding of a same cycle writeback
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd5, 4'b0001));
        apply(make_req(1'b0, '0, 1'b1, 5'd5, 1'b0, '0, 4'b0001),
              make_wb(5'd5, 32'h5a5a_0505), 1'b0, CONTEXT_ZERO);
        wait_grant();

        // waw on x9, then link register
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd9, 4'b0001));
        repeat (2) apply(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd9, 4'b0001), '0, 1'b0, CONTEXT_ZERO);
        apply('0, make_wb(5'd9, 32'h0000_0909), 1'b0, CONTEXT_ZERO);
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, LR_ADDR, 4'b0001));
        idle(1);
        apply('0, make_wb(LR_ADDR, 32'h0000_1234), 1'b0, CONTEXT_ZERO);
        idle(1);

        // squash of region 0010, region 0100 survives
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd10, 4'b0010));
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd11, 4'b0010));
        issue(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd12, 4'b0100));
        apply(make_req(1'b0, '0, 1'b0, '0, 1'b1, 5'd13, 4'b0010), '0, 1'b1, 4'b0010);
        repeat (2) apply(make_req(1'b1, 5'd10, 1'b1, 5'd12, 1'b0, '0, 4'b0100),
                         '0, 1'b0, CONTEXT_ZERO);
        apply(make_req(1'b1, 5'd11, 1'b0, '0, 1'b1, 5'd10, 4'b0100), '0, 1'b0, CONTEXT_ZERO);
        apply('0, make_wb(5'd12, 32'h0000_0c0c), 1'b0, CONTEXT_ZERO);
        apply('0, make_wb(5'd10, 32'h0000_0a0a), 1'b0, CONTEXT_ZERO);

        random_mix(400);
        idle(2);

        $display("Done: no errors");
        $finish;
    end

endmodule

/* compile.f */
src/regman_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/ctx_scoreboard.sv
src/reg_manage.sv
src/regman_top.sv
tests/tb_regman.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_regman
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
